//--- common/adxl_pkg.sv
`default_nettype none

package adxl_pkg;

    // register mirror geometry
    localparam int mirror_bytes = 64;
    localparam int mirror_words = 16;       // 32-bit host words

    // poll command contents
    localparam logic [7:0] poll_length         = 8'h3A; // bytes read per poll
    localparam logic [7:0] pointer_start       = 8'h00; // first register of the burst
    localparam logic [7:0] pointer_write_count = 8'h01; // head byte of the pointer write

    // direction bit, user byte bit 0
    localparam logic rw_write = 1'b0;
    localparam logic rw_read  = 1'b1;

    // command FIFO sizing
    localparam int fifo_depth       = 16;
    localparam int fifo_afull_level = 13;  // room for the three bytes of one poll

    typedef enum logic [1:0] {
        idle,          // wait for a poll request
        send_pointer,  // byte count + register pointer, write direction
        send_read,     // read length, read direction
        receive        // reply bytes until tlast
    } seq_state_t;

endpackage

`default_nettype wire

//--- common/cmd_stream_if.sv
`timescale 1ns/1ps
`default_nettype none

interface cmd_stream_if;

    logic [7:0] data;   // command byte
    logic [7:0] user;   // i2c address and direction
    logic       last;   // final byte of a command
    logic       wr_en;  // push strobe
    logic       afull;  // FIFO nearly full

    modport source (
        output data,
        output user,
        output last,
        output wr_en,
        input  afull
    );

    modport sink (
        input  data,
        input  user,
        input  last,
        input  wr_en,
        output afull
    );

endinterface

`default_nettype wire

//--- dv/tb_adxl_poller.sv
`timescale 1ns/1ps
`default_nettype none

module tb_adxl_poller;

    localparam int     test_interval = 12;
    localparam int     poll_cycles   = 2 * (3 + adxl_pkg::poll_length) + test_interval + 40;
    localparam longint watchdog_ns   = 4 * 20 * poll_cycles * 100;  // 20 polls, 4x margin

    logic        CLK             = 1'b0;
    logic        RESET           = 1'b1;
    logic [3:0]  raddr           = '0;
    logic [31:0] rdata;
    logic [6:0]  i2c_address     = 7'h53;
    logic        single_request  = 1'b0;
    logic        interval_enable = 1'b0;
    logic [31:0] interval        = test_interval;
    logic        request_done;
    logic [7:0]  m_tdata;
    logic [7:0]  m_tuser;
    logic        m_tvalid;
    logic        m_tlast;
    logic        m_tready        = 1'b0;
    logic [7:0]  s_tdata         = '0;
    logic        s_tvalid        = 1'b0;
    logic        s_tlast         = 1'b0;
    logic        s_tready;

    // device model and scoreboard state
    logic [31:0] rng         = 32'h86f4_51be;
    logic [7:0]  exp_mem [adxl_pkg::mirror_bytes] = '{default: 8'h00};
    logic [5:0]  rx_index    = '0;
    int          cmd_pos     = 0;      // position within the three command bytes
    int          reply_left  = 0;
    int          since_last  = 0;      // cycles since the last accepted s_tlast
    int          polls_done  = 0;
    logic        stalled     = 1'b0;
    logic [7:0]  held_data   = '0;
    logic        started     = 1'b0;
    logic        timer_mode  = 1'b0;
    logic        expect_done = 1'b0;
    logic        rd_check    = 1'b0;
    logic        chk_q1      = 1'b0;
    logic        chk_q2      = 1'b0;
    logic [3:0]  raddr_q1    = '0;
    logic [3:0]  raddr_q2    = '0;
    logic [7:0]  exp_tdata;
    logic [7:0]  exp_tuser;
    logic        exp_tlast;
    logic [31:0] exp_rdata;

    adxl_poller u_adxl_poller (
        .CLK (CLK), .RESET (RESET), .raddr (raddr), .rdata (rdata),
        .i2c_address (i2c_address), .single_request (single_request),
        .interval_enable (interval_enable), .interval (interval), .request_done (request_done),
        .m_tdata (m_tdata), .m_tuser (m_tuser), .m_tvalid (m_tvalid), .m_tlast (m_tlast),
        .m_tready (m_tready), .s_tdata (s_tdata), .s_tvalid (s_tvalid), .s_tlast (s_tlast),
        .s_tready (s_tready)
    );

    always #50 CLK = ~CLK;

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    task automatic flag_mismatch(input string name, input logic [31:0] expected,
                                 input logic [31:0] actual);
        $display("MISMATCH time=%0t signal=%s expected=%h actual=%h", $time, name, expected, actual);
        $display("Checks failed");
        $fatal(1, "stopped at first mismatch");
    endtask

    task automatic stop_on_error(input string what);
        $display("ERROR time=%0t %s", $time, what);
        $display("Checks failed");
        $fatal(1, "stopped at first error");
    endtask

    // pointer write: count then pointer, then the read length
    assign exp_tdata = (cmd_pos == 0) ? adxl_pkg::pointer_write_count :
                       (cmd_pos == 1) ? adxl_pkg::pointer_start : adxl_pkg::poll_length;
    assign exp_tuser = {i2c_address, (cmd_pos == 2) ? adxl_pkg::rw_read : adxl_pkg::rw_write};
    assign exp_tlast = (cmd_pos != 0);
    assign exp_rdata = {exp_mem[{raddr_q2, 2'd3}], exp_mem[{raddr_q2, 2'd2}],
                        exp_mem[{raddr_q2, 2'd1}], exp_mem[{raddr_q2, 2'd0}]};

    // I2C bridge model
    always @(posedge CLK) begin
        logic cmd_xfer;
        logic rx_xfer;
        cmd_xfer  = m_tvalid && m_tready;
        rx_xfer   = s_tvalid && s_tready;
        stalled   = m_tvalid && !m_tready;
        held_data = m_tdata;
        rng       = xorshift32(rng);
        if (RESET) begin
            cmd_pos    = 0;
            reply_left = 0;
            since_last = 0;
            polls_done = 0;
            stalled    = 1'b0;
        end else begin
            since_last = since_last + 1;
            if (rx_xfer) begin
                exp_mem[rx_index] = s_tdata;
                rx_index = rx_index + 6'd1;  // wraps at 64
                if (s_tlast) begin
                    polls_done = polls_done + 1;
                    since_last = 0;
                end
            end
            if (cmd_xfer) begin
                if (cmd_pos == 2) begin
                    reply_left = adxl_pkg::poll_length;
                    rx_index   = 6'(adxl_pkg::pointer_start);
                end
                cmd_pos = (cmd_pos == 2) ? 0 : cmd_pos + 1;
            end
        end
        #1;
        m_tready = (rng[1:0] != 2'b00);  // roughly 3 of 4 cycles ready
        if (RESET) begin
            s_tvalid = 1'b0;
            s_tlast  = 1'b0;
        end else if (rx_xfer || !s_tvalid) begin
            if (reply_left != 0 && rng[2]) begin
                s_tdata    = rng[15:8];
                s_tvalid   = 1'b1;
                s_tlast    = (reply_left == 1);
                reply_left = reply_left - 1;
            end else begin
                s_tvalid = 1'b0;
                s_tlast  = 1'b0;
            end
        end
    end

    // host read pipeline, rdata lands two cycles after raddr
    always @(posedge CLK) begin
        raddr_q1 <= raddr;
        raddr_q2 <= raddr_q1;
        chk_q1   <= rd_check;
        chk_q2   <= chk_q1;
    end

    a_quiet_tvalid : assert property (@(posedge CLK) disable iff (RESET)
        !started |-> !m_tvalid) else flag_mismatch("m_tvalid", 0, $sampled(m_tvalid));
    a_quiet_tready : assert property (@(posedge CLK) disable iff (RESET)
        !started |-> !s_tready) else flag_mismatch("s_tready", 0, $sampled(s_tready));
    a_quiet_done : assert property (@(posedge CLK) disable iff (RESET)
        !started |-> !request_done) else flag_mismatch("request_done", 0, $sampled(request_done));

    a_cmd_data : assert property (@(posedge CLK) disable iff (RESET)
        m_tvalid && m_tready |-> m_tdata == exp_tdata)
        else flag_mismatch("m_tdata", $sampled(exp_tdata), $sampled(m_tdata));
    a_cmd_user : assert property (@(posedge CLK) disable iff (RESET)
        m_tvalid && m_tready |-> m_tuser == exp_tuser)
        else flag_mismatch("m_tuser", $sampled(exp_tuser), $sampled(m_tuser));
    a_cmd_last : assert property (@(posedge CLK) disable iff (RESET)
        m_tvalid && m_tready |-> m_tlast == exp_tlast)
        else flag_mismatch("m_tlast", $sampled(exp_tlast), $sampled(m_tlast));

    a_hold_valid : assert property (@(posedge CLK) disable iff (RESET)
        stalled |-> m_tvalid) else flag_mismatch("m_tvalid", 1, $sampled(m_tvalid));
    a_hold_data : assert property (@(posedge CLK) disable iff (RESET)
        stalled |-> m_tdata == held_data)
        else flag_mismatch("m_tdata", $sampled(held_data), $sampled(m_tdata));

    a_mirror_word : assert property (@(posedge CLK) disable iff (RESET)
        chk_q2 |-> rdata == exp_rdata)
        else flag_mismatch("rdata", $sampled(exp_rdata), $sampled(rdata));

    a_interval_gap : assert property (@(posedge CLK) disable iff (RESET)
        timer_mode && $rose(m_tvalid) |-> since_last >= interval + 1)
        else stop_on_error("interval poll started too soon after the previous reply");

    a_done_after_last : assert property (@(posedge CLK) disable iff (RESET)
        s_tvalid && s_tready && s_tlast |=> request_done == expect_done)
        else flag_mismatch("request_done", $sampled(expect_done), $sampled(request_done));
    a_done_only_after_last : assert property (@(posedge CLK) disable iff (RESET)
        request_done |-> $past(s_tvalid && s_tready && s_tlast))
        else stop_on_error("request_done pulsed without an accepted s_tlast");

    task automatic next_cycle();
        @(posedge CLK);
        #1;
    endtask

    task automatic single_poll();
        started        = 1'b1;
        expect_done    = 1'b1;
        single_request = 1'b1;
        next_cycle();
        single_request = 1'b0;
        while (!request_done) begin
            next_cycle();
        end
        next_cycle();
    endtask

    task automatic sweep_mirror();
        int w;
        for (w = 0; w < adxl_pkg::mirror_words; w++) begin
            raddr    = w[3:0];
            rd_check = 1'b1;
            next_cycle();
        end
        rd_check = 1'b0;
        repeat (3) next_cycle();
    endtask

    initial begin
        int target;
        repeat (8) @(posedge CLK);
        #1 RESET = 1'b0;
        repeat (6) next_cycle();  // outputs stay quiet without a request
        repeat (3) begin
            single_poll();
            sweep_mirror();
        end
        expect_done     = 1'b0;
        timer_mode      = 1'b1;
        interval_enable = 1'b1;
        target          = polls_done + 8;
        while (polls_done < target) begin
            next_cycle();
        end
        interval_enable = 1'b0;
        timer_mode      = 1'b0;
        repeat (test_interval + 4) next_cycle();
        sweep_mirror();
        single_poll();
        sweep_mirror();
        repeat (4) next_cycle();
        $display("All checks passed");
        $finish;
    end

    initial begin
        #(watchdog_ns);
        $display("ERROR time=%0t watchdog expired before the polls completed", $time);
        $display("Checks failed");
        $fatal(1, "watchdog timeout");
    end

endmodule

`default_nettype wire

//--- logic/adxl_poller.sv
`timescale 1ns/1ps
`default_nettype none

module adxl_poller (
    input  logic        CLK,
    input  logic        RESET,
    // host read port
    input  logic [3:0]  raddr,
    output logic [31:0] rdata,
    // control
    input  logic [6:0]  i2c_address,
    input  logic        single_request,
    input  logic        interval_enable,
    input  logic [31:0] interval,
    output logic        request_done,
    // commands to the I2C bridge
    output logic [7:0]  m_tdata,
    output logic [7:0]  m_tuser,
    output logic        m_tvalid,
    output logic        m_tlast,
    input  logic        m_tready,
    // reply bytes from the bridge
    input  logic [7:0]  s_tdata,
    input  logic        s_tvalid,
    input  logic        s_tlast,
    output logic        s_tready
);

    logic       poll_request;
    logic       poll_single;
    logic       busy;
    logic       mirror_wr_en;
    logic [5:0] mirror_wr_addr;
    logic [7:0] mirror_wr_data;

    cmd_stream_if u_cmd ();

    poll_scheduler u_poll_scheduler (
        .CLK             (CLK),
        .RESET           (RESET),
        .single_request  (single_request),
        .interval_enable (interval_enable),
        .interval        (interval),
        .busy            (busy),
        .poll_request    (poll_request),
        .poll_single     (poll_single)
    );

    poll_sequencer u_poll_sequencer (
        .CLK          (CLK),
        .RESET        (RESET),
        .poll_request (poll_request),
        .poll_single  (poll_single),
        .i2c_address  (i2c_address),
        .busy         (busy),
        .request_done (request_done),
        .cmd          (u_cmd.source),
        .s_tdata      (s_tdata),
        .s_tvalid     (s_tvalid),
        .s_tlast      (s_tlast),
        .s_tready     (s_tready),
        .wr_en        (mirror_wr_en),
        .wr_addr      (mirror_wr_addr),
        .wr_data      (mirror_wr_data)
    );

    cmd_fifo u_cmd_fifo (
        .CLK      (CLK),
        .RESET    (RESET),
        .cmd      (u_cmd.sink),
        .m_tdata  (m_tdata),
        .m_tuser  (m_tuser),
        .m_tlast  (m_tlast),
        .m_tvalid (m_tvalid),
        .m_tready (m_tready)
    );

    reg_mirror u_reg_mirror (
        .CLK     (CLK),
        .wr_en   (mirror_wr_en),
        .wr_addr (mirror_wr_addr),
        .wr_data (mirror_wr_data),
        .raddr   (raddr),
        .rdata   (rdata)
    );

endmodule

`default_nettype wire

//--- logic/cmd_fifo.sv
`timescale 1ns/1ps
`default_nettype none

module cmd_fifo (
    input  logic       CLK,
    input  logic       RESET,
    cmd_stream_if.sink cmd,
    output logic [7:0] m_tdata,
    output logic [7:0] m_tuser,
    output logic       m_tlast,
    output logic       m_tvalid,
    input  logic       m_tready
);

    logic [7:0] mem_data [adxl_pkg::fifo_depth];
    logic [7:0] mem_user [adxl_pkg::fifo_depth];
    logic       mem_last [adxl_pkg::fifo_depth];

    logic [$clog2(adxl_pkg::fifo_depth)-1:0]   wptr;
    logic [$clog2(adxl_pkg::fifo_depth)-1:0]   rptr;
    logic [$clog2(adxl_pkg::fifo_depth+1)-1:0] count;  // occupancy
    logic                                      pop;

    // head entry is the outgoing beat
    assign m_tvalid  = (count != '0);
    assign m_tdata   = mem_data[rptr];
    assign m_tuser   = mem_user[rptr];
    assign m_tlast   = mem_last[rptr];
    assign pop       = m_tvalid & m_tready;
    assign cmd.afull = (count >= adxl_pkg::fifo_afull_level);

    always_ff @(posedge CLK) begin
        if (cmd.wr_en) begin
            mem_data[wptr] <= cmd.data;
            mem_user[wptr] <= cmd.user;
            mem_last[wptr] <= cmd.last;
        end
    end

    always_ff @(posedge CLK) begin
        if (RESET) begin
            wptr  <= '0;
            rptr  <= '0;
            count <= '0;
        end else begin
            if (cmd.wr_en) begin
                wptr <= wptr + 1'b1;  // natural wrap, depth is a power of two
            end
            if (pop) begin
                rptr <= rptr + 1'b1;
            end
            case ({cmd.wr_en, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // the sequencer relies on afull leaving enough slack
    a_no_write_when_full : assert property (
        @(posedge CLK) disable iff (RESET)
        cmd.wr_en |-> (count != adxl_pkg::fifo_depth)
    ) else $error("command FIFO written while full");

endmodule

`default_nettype wire

//--- logic/reg_mirror.sv
`timescale 1ns/1ps
`default_nettype none

module reg_mirror (
    input  logic        CLK,
    input  logic        wr_en,
    input  logic [5:0]  wr_addr,
    input  logic [7:0]  wr_data,
    input  logic [3:0]  raddr,
    output logic [31:0] rdata
);

    // byte lanes of each host word, lane 0 = bits 7:0
    logic [adxl_pkg::mirror_bytes/adxl_pkg::mirror_words-1:0][7:0]
        mem [adxl_pkg::mirror_words] = '{default: '0};

    logic [31:0] rd_stage;  // first read stage

    always_ff @(posedge CLK) begin
        if (wr_en) begin
            mem[wr_addr[5:2]][wr_addr[1:0]] <= wr_data;  // word b/4, lane b mod 4
        end
    end

    // two register stages on the host side
    always_ff @(posedge CLK) begin
        rd_stage <= mem[raddr];
        rdata    <= rd_stage;
    end

endmodule

`default_nettype wire

//--- poll/poll_scheduler.sv
`timescale 1ns/1ps
`default_nettype none

module poll_scheduler (
    input  logic        CLK,
    input  logic        RESET,
    input  logic        single_request,
    input  logic        interval_enable,
    input  logic [31:0] interval,
    input  logic        busy,
    output logic        poll_request,
    output logic        poll_single
);

    logic [31:0] count;        // interval down-counter
    logic        hold;         // a poll is pending or running
    logic        single_fire;
    logic        timer_fire;

    // the pulse itself counts as pending, busy rises one cycle later
    assign hold        = busy | poll_request;
    assign single_fire = single_request & ~hold;
    assign timer_fire  = interval_enable & ~hold & (count == '0);

    always_ff @(posedge CLK) begin
        if (RESET) begin
            poll_request <= 1'b0;
            poll_single  <= 1'b0;
            count        <= interval;
        end else begin
            poll_request <= single_fire | timer_fire;
            poll_single  <= single_fire;  // tag for request_done
            if (!interval_enable || hold) begin
                count <= interval;        // reload
            end else if (count != '0) begin
                count <= count - 32'd1;
            end
        end
    end

    // a new poll must wait for the sequencer to return to idle
    a_no_request_while_busy : assert property (
        @(posedge CLK) disable iff (RESET)
        poll_request |-> !busy
    ) else $error("poll request raised while sequencer busy");

endmodule

`default_nettype wire

//--- poll/poll_sequencer.sv
`timescale 1ns/1ps
`default_nettype none

module poll_sequencer (
    input  logic               CLK,
    input  logic               RESET,
    input  logic               poll_request,
    input  logic               poll_single,
    input  logic [6:0]         i2c_address,
    output logic               busy,
    output logic               request_done,
    cmd_stream_if.source       cmd,
    input  logic [7:0]         s_tdata,
    input  logic               s_tvalid,
    input  logic               s_tlast,
    output logic               s_tready,
    output logic               wr_en,
    output logic [5:0]         wr_addr,
    output logic [7:0]         wr_data
);

    adxl_pkg::seq_state_t state;

    logic       ptr_cnt;    // 0 = byte count, 1 = pointer
    logic       single_q;   // current poll came from single_request
    logic [5:0] rx_addr;    // mirror byte address
    logic       rx_accept;

    assign busy      = (state != adxl_pkg::idle);
    assign s_tready  = (state == adxl_pkg::receive);
    assign rx_accept = s_tready & s_tvalid;

    // reply bytes go straight to the mirror
    assign wr_en   = rx_accept;
    assign wr_addr = rx_addr;
    assign wr_data = s_tdata;

    always_ff @(posedge CLK) begin
        if (RESET) begin
            state        <= adxl_pkg::idle;
            ptr_cnt      <= 1'b0;
            single_q     <= 1'b0;
            rx_addr      <= '0;
            cmd.wr_en    <= 1'b0;
            request_done <= 1'b0;
        end else begin
            cmd.wr_en    <= 1'b0;
            request_done <= 1'b0;
            case (state)
                adxl_pkg::idle: begin
                    if (poll_request) begin
                        state    <= adxl_pkg::send_pointer;
                        ptr_cnt  <= 1'b0;
                        single_q <= poll_single;
                        rx_addr  <= 6'(adxl_pkg::pointer_start);
                    end
                end
                adxl_pkg::send_pointer: begin
                    if (!cmd.afull) begin
                        cmd.wr_en <= 1'b1;
                        ptr_cnt   <= 1'b1;
                        if (ptr_cnt) begin
                            state <= adxl_pkg::send_read;
                        end
                    end
                end
                adxl_pkg::send_read: begin
                    if (!cmd.afull) begin
                        cmd.wr_en <= 1'b1;
                        state     <= adxl_pkg::receive;
                    end
                end
                adxl_pkg::receive: begin
                    if (rx_accept) begin
                        rx_addr <= rx_addr + 6'd1;  // wraps at 64
                        if (s_tlast) begin
                            state        <= adxl_pkg::idle;
                            request_done <= single_q;
                        end
                    end
                end
                default: state <= adxl_pkg::idle;
            endcase
        end
    end

    // command payload, only sampled by the FIFO when wr_en is set
    always_ff @(posedge CLK) begin
        if (state == adxl_pkg::send_pointer) begin
            cmd.data <= ptr_cnt ? adxl_pkg::pointer_start : adxl_pkg::pointer_write_count;
            cmd.user <= {i2c_address, adxl_pkg::rw_write};
            cmd.last <= ptr_cnt;
        end else if (state == adxl_pkg::send_read) begin
            cmd.data <= adxl_pkg::poll_length;
            cmd.user <= {i2c_address, adxl_pkg::rw_read};
            cmd.last <= 1'b1;
        end
    end

endmodule

`default_nettype wire

//--- verilog.f
common/adxl_pkg.sv
common/cmd_stream_if.sv
poll/poll_scheduler.sv
poll/poll_sequencer.sv
logic/cmd_fifo.sv
logic/reg_mirror.sv
logic/adxl_poller.sv
dv/tb_adxl_poller.sv
